//--- verilog/i2c_bridge_params.svh
`ifndef I2C_BRIDGE_PARAMS_SVH
`define I2C_BRIDGE_PARAMS_SVH

// Pin filter length in clocks
`define MM_IIC_GLITCH 6

// Hold after the SCL fall before the slave lets go of SDA at the end of an ACK
`define MM_IIC_NEGEDGE_DLY 10

// Words per FIFO, power of two
`define BRIDGE_FIFO_DEPTH 4

// Extra addresses the slave answers to, besides its own and general call
`define IIC_ALIAS_ADDR0 7'h40
`define IIC_ALIAS_ADDR1 7'h41

`endif

//--- verilog/i2c_bridge_pkg.sv
package i2c_bridge_pkg;

	typedef logic [31:0] word_t;     // One FIFO word, four bus bytes
	typedef logic [7:0]  byte_t;
	typedef logic [6:0]  i2c_addr_t;
	typedef logic [15:0] stat_cnt_t;

	// Slave engine states
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		ADDR  = 3'd1,   // Shifting the address byte
		DWR   = 3'd2,   // Master writes data
		DRD   = 3'd3,   // Slave sends data
		ACKO  = 3'd4,   // Slave acks a data byte
		AACKO = 3'd5,   // Slave acks the address
		ACKI  = 3'd6    // Master acks a read byte
	} phy_state_t;

endpackage

//--- verilog/i2c_line_if.sv
`timescale 1ns/1ns

interface i2c_line_if;

	logic scl;        // Filtered levels
	logic sda;
	logic start;      // One-cycle event pulses
	logic stop;
	logic scl_rise;
	logic scl_fall;

	modport src (
		output scl, sda, start, stop, scl_rise, scl_fall
	);

	modport snk (
		input scl, sda, start, stop, scl_rise, scl_fall
	);

endinterface

//--- verilog/i2c_line_filter.sv
`timescale 1ns/1ns
`include "i2c_bridge_params.svh"

module i2c_line_filter (
	input  logic     clk,
	input  logic     rst,
	input  logic     scl_i,
	input  logic     sda_i,
	i2c_line_if.src  line
);

	logic [`MM_IIC_GLITCH-1:0] scl_f;   // Low taps double as the synchronizer
	logic [`MM_IIC_GLITCH-1:0] sda_f;
	logic scl, scl_r;
	logic sda, sda_r;

	// Level moves only when all older taps agree, else it holds
	function automatic logic settle(input logic [`MM_IIC_GLITCH-1:0] taps, input logic level);
		if (&taps[`MM_IIC_GLITCH-1:2])
			return 1'b1;
		else if (!(|taps[`MM_IIC_GLITCH-1:2]))
			return 1'b0;
		return level;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			scl_f <= '1;   // Idle bus is high
			sda_f <= '1;
			scl   <= 1'b1;
			sda   <= 1'b1;
			scl_r <= 1'b1;
			sda_r <= 1'b1;
		end else begin
			scl_f <= {scl_f[`MM_IIC_GLITCH-2:0], scl_i};
			sda_f <= {sda_f[`MM_IIC_GLITCH-2:0], sda_i};
			scl   <= settle(scl_f, scl);
			sda   <= settle(sda_f, sda);
			scl_r <= scl;
			sda_r <= sda;
		end
	end

	// ------------------------------------------------------------------
	// Bus events from previous and current filtered levels
	// ------------------------------------------------------------------
	assign line.scl      = scl;
	assign line.sda      = sda;
	assign line.start    = scl_r && sda_r && scl && !sda;
	assign line.stop     = scl_r && !sda_r && scl && sda;
	assign line.scl_rise = !scl_r && scl;
	assign line.scl_fall = scl_r && !scl;

endmodule

//--- verilog/i2c_slave_phy.sv
`timescale 1ns/1ns
`include "i2c_bridge_params.svh"

module i2c_slave_phy
	import i2c_bridge_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	i2c_line_if.snk   line,
	input  i2c_addr_t own_addr_i,
	input  logic      rx_full_i,
	output logic      rx_push_o,
	output word_t     rx_word_o,
	input  logic      tx_empty_i,
	output logic      tx_pop_o,
	input  word_t     tx_word_i,
	output logic      sda_pull_o,
	output byte_t     byte_o,
	output logic      byte_valid_o,
	output i2c_addr_t addr_o,
	output logic      wr_done_o,
	output logic      rd_done_o,
	output logic      rd_err_o
);

	phy_state_t state, nxt_state;
	word_t      shift_buf;      // Address, write data and read data all pass here
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;       // Bytes within the current word
	logic [5:0] dly_cnt;
	logic       neg_dly;
	logic       get_8bit;
	logic       start_seen;
	logic       acki_f;         // Master ACK level, low means more
	logic       addr_ack;
	logic       rw_flg;
	logic       addr_match;
	logic       addr_ok;
	logic       bit_err;

	assign neg_dly  = dly_cnt == 6'(`MM_IIC_NEGEDGE_DLY);
	assign get_8bit = (&bit_cnt) && line.scl_fall;
	assign bit_err  = line.scl_rise && (line.sda == sda_pull_o);   // Bus differs from our bit

	assign addr_match = (shift_buf[7:1] == own_addr_i) ||
		(shift_buf[7:1] == `IIC_ALIAS_ADDR0) ||
		(shift_buf[7:1] == `IIC_ALIAS_ADDR1) ||
		(shift_buf[7:1] == 7'h00);
	// Read needs a word to send, write needs room for one
	assign addr_ok = addr_match && (shift_buf[0] ? !tx_empty_i : !rx_full_i);

	// ------------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------------
	always_comb begin
		nxt_state = state;
		if (line.start || line.stop)
			nxt_state = IDLE;
		else
			case (state)
			IDLE:  if (start_seen && line.scl_fall) nxt_state = ADDR;
			ADDR:  if (get_8bit) nxt_state = AACKO;
			DWR:   if (get_8bit) nxt_state = ACKO;
			DRD:   if (bit_err) nxt_state = IDLE;
				else if (get_8bit) nxt_state = ACKI;
			ACKO:  if (neg_dly) nxt_state = DWR;
			AACKO: if (neg_dly) nxt_state = !addr_ack ? IDLE : (rw_flg ? DRD : DWR);
			ACKI:  if (line.scl_fall) nxt_state = acki_f ? IDLE : DRD;
			default: nxt_state = IDLE;
			endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= nxt_state;
	end

	always_ff @(posedge clk) begin
		if (rst)
			start_seen <= 1'b0;
		else if (line.start)
			start_seen <= 1'b1;
		else if (line.scl_fall)
			start_seen <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst || state == IDLE) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end else begin
			if ((state == ADDR || state == DWR || state == DRD) && line.scl_fall)
				bit_cnt <= bit_cnt + 3'd1;
			if ((state == DWR || state == DRD) && get_8bit)
				byte_cnt <= byte_cnt + 2'd1;
		end
	end

	// Counts from the ACK clock fall up to the release point
	always_ff @(posedge clk) begin
		if (rst)
			dly_cnt <= '0;
		else if (line.scl_fall && (state == ACKO || state == AACKO))
			dly_cnt <= 6'd1;
		else if (dly_cnt != '0 && !neg_dly)
			dly_cnt <= dly_cnt + 6'd1;
		else
			dly_cnt <= '0;
	end

	// ------------------------------------------------------------------
	// Address and acknowledge
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || nxt_state == IDLE)
			addr_ack <= 1'b0;
		else if (state == ADDR && get_8bit)
			addr_ack <= addr_ok;
	end

	always_ff @(posedge clk) begin
		if (rst)
			rw_flg <= 1'b0;
		else if (state == ADDR && get_8bit)
			rw_flg <= shift_buf[0];
	end

	always_ff @(posedge clk) begin
		if (state == ADDR && get_8bit)
			addr_o <= shift_buf[7:1];
	end

	always_ff @(posedge clk) begin
		if (rst)
			acki_f <= 1'b1;
		else if (state == ACKI && line.scl_rise)
			acki_f <= line.sda;
	end

	// Pull changes after SCL falls, read errors and bus events
	always_ff @(posedge clk) begin
		if (rst || line.start || line.stop)
			sda_pull_o <= 1'b0;
		else if (state == ADDR && get_8bit)
			sda_pull_o <= addr_ok;
		else if (state == DWR && get_8bit)
			sda_pull_o <= !((&byte_cnt) && rx_full_i);   // NACK a word with no room
		else if (state == ACKO && neg_dly)
			sda_pull_o <= 1'b0;
		else if (state == AACKO && neg_dly)
			sda_pull_o <= addr_ack && rw_flg && !shift_buf[31];   // First read bit
		else if (state == DRD && (get_8bit || bit_err))
			sda_pull_o <= 1'b0;   // Let the master ack
		else if (state == DRD && line.scl_fall)
			sda_pull_o <= !shift_buf[31];
		else if (state == ACKI && line.scl_fall)
			sda_pull_o <= !acki_f && !shift_buf[31];
	end

	// ------------------------------------------------------------------
	// Data path and FIFO handshakes
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (tx_pop_o)
			shift_buf <= tx_word_i;
		else if (line.scl_rise && (state == ADDR || state == DWR || state == DRD))
			shift_buf <= {shift_buf[30:0], (state == DRD) ? 1'b0 : line.sda};
	end

	assign rx_word_o = shift_buf;
	assign byte_o    = shift_buf[7:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_push_o    <= 1'b0;
			tx_pop_o     <= 1'b0;
			byte_valid_o <= 1'b0;
			wr_done_o    <= 1'b0;
			rd_done_o    <= 1'b0;
			rd_err_o     <= 1'b0;
		end else begin
			rx_push_o    <= state == DWR && get_8bit && (&byte_cnt) && !rx_full_i;
			tx_pop_o     <= (state == AACKO && line.scl_rise && addr_ack && rw_flg) ||
				(state == ACKI && line.scl_rise && !line.sda && byte_cnt == 2'd0 &&
				!tx_empty_i);
			byte_valid_o <= state == DWR && get_8bit;
			wr_done_o    <= state == DWR && (line.start || line.stop);
			rd_done_o    <= state == ACKI && line.scl_fall && acki_f;
			rd_err_o     <= state == DRD && bit_err;
		end
	end

	a_push_room: assert property (@(posedge clk) disable iff (rst) rx_push_o |-> !rx_full_i)
		else $error("ERR %0t: receive push while FIFO full", $time);

	a_idle_release: assert property (@(posedge clk) disable iff (rst)
		state == IDLE |-> !sda_pull_o)
		else $error("ERR %0t: SDA pulled in IDLE", $time);

endmodule

//--- verilog/word_fifo.sv
`timescale 1ns/1ns

module word_fifo
	import i2c_bridge_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  push_i,
	input  word_t data_i,
	input  logic  pop_i,
	output word_t data_o,
	output logic  full_o,
	output logic  empty_o
);

	localparam int AW = $clog2(DEPTH);

	word_t         mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;     // Occupancy
	logic          wr_en;
	logic          rd_en;

	assign full_o  = count == (AW+1)'(DEPTH);
	assign empty_o = count == '0;
	assign wr_en   = push_i && !full_o;
	assign rd_en   = pop_i && !empty_o;

	// Head word straight from the storage registers
	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) push_i |-> !full_o)
		else $error("ERR %0t: FIFO push while full", $time);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o)
		else $error("ERR %0t: FIFO pop while empty", $time);

endmodule

//--- verilog/i2c_bridge_status.sv
`timescale 1ns/1ns

module i2c_bridge_status
	import i2c_bridge_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      wr_done_i,
	input  logic      rd_done_i,
	input  logic      rd_err_i,
	output stat_cnt_t wr_count_o,
	output stat_cnt_t rd_count_o,
	output stat_cnt_t err_count_o
);

	// Stops at all ones
	function automatic stat_cnt_t sat_inc(input stat_cnt_t cnt);
		return (&cnt) ? cnt : cnt + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_count_o  <= '0;
			rd_count_o  <= '0;
			err_count_o <= '0;
		end else begin
			if (wr_done_i)
				wr_count_o <= sat_inc(wr_count_o);
			if (rd_done_i)
				rd_count_o <= sat_inc(rd_count_o);
			if (rd_err_i)
				err_count_o <= sat_inc(err_count_o);
		end
	end

	// Events come from different engine states
	a_one_event: assert property (@(posedge clk) disable iff (rst)
		$onehot0({wr_done_i, rd_done_i, rd_err_i}))
		else $error("ERR %0t: status events collide", $time);

endmodule

//--- verilog/i2c_bridge_top.sv
`timescale 1ns/1ns
`include "i2c_bridge_params.svh"

module i2c_bridge_top
	import i2c_bridge_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      scl_i,
	input  logic      sda_i,
	output logic      sda_pull_o,    // Open-drain enable, high pulls SDA low
	input  i2c_addr_t own_addr_i,
	input  logic      rx_pop_i,
	output word_t     rx_word_o,
	output logic      rx_empty_o,
	input  logic      tx_push_i,
	input  word_t     tx_word_i,
	output logic      tx_full_o,
	output byte_t     byte_o,
	output logic      byte_valid_o,
	output i2c_addr_t addr_o,
	output stat_cnt_t wr_count_o,
	output stat_cnt_t rd_count_o,
	output stat_cnt_t err_count_o
);

	word_t rx_word;
	word_t tx_word;
	logic  rx_push, rx_full;
	logic  tx_pop, tx_empty;
	logic  wr_done, rd_done, rd_err;

	i2c_line_if line_if ();

	i2c_line_filter i2c_line_filter_i (
		.clk   (clk),
		.rst   (rst),
		.scl_i (scl_i),
		.sda_i (sda_i),
		.line  (line_if.src)
	);

	i2c_slave_phy i2c_slave_phy_i (
		.clk          (clk),
		.rst          (rst),
		.line         (line_if.snk),
		.own_addr_i   (own_addr_i),
		.rx_full_i    (rx_full),
		.rx_push_o    (rx_push),
		.rx_word_o    (rx_word),
		.tx_empty_i   (tx_empty),
		.tx_pop_o     (tx_pop),
		.tx_word_i    (tx_word),
		.sda_pull_o   (sda_pull_o),
		.byte_o       (byte_o),
		.byte_valid_o (byte_valid_o),
		.addr_o       (addr_o),
		.wr_done_o    (wr_done),
		.rd_done_o    (rd_done),
		.rd_err_o     (rd_err)
	);

	// Master to host
	word_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) rx_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.push_i  (rx_push),
		.data_i  (rx_word),
		.pop_i   (rx_pop_i),
		.data_o  (rx_word_o),
		.full_o  (rx_full),
		.empty_o (rx_empty_o)
	);

	// Host to master
	word_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) tx_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.push_i  (tx_push_i),
		.data_i  (tx_word_i),
		.pop_i   (tx_pop),
		.data_o  (tx_word),
		.full_o  (tx_full_o),
		.empty_o (tx_empty)
	);

	i2c_bridge_status i2c_bridge_status_i (
		.clk         (clk),
		.rst         (rst),
		.wr_done_i   (wr_done),
		.rd_done_i   (rd_done),
		.rd_err_i    (rd_err),
		.wr_count_o  (wr_count_o),
		.rd_count_o  (rd_count_o),
		.err_count_o (err_count_o)
	);

endmodule

//--- verification/i2c_master_tasks.svh
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// Bit-level I2C master, included inside the testbench module
// Uses clk, scl_m, sda_m and the resolved bus level sda_bus

localparam int HALF_CLKS  = 32;              // SCL half period in clocks
localparam int QUART_CLKS = HALF_CLKS / 2;   // SDA moves mid low phase

task automatic idle_clks(input int n);
	repeat (n) @(negedge clk);
endtask

// One SCL pulse, starting and ending with SCL low
task automatic clock_bit(input logic drive, output logic level);
	idle_clks(QUART_CLKS);
	sda_m = drive;
	idle_clks(QUART_CLKS);
	scl_m = 1'b1;
	idle_clks(QUART_CLKS);
	level = sda_bus;   // Sampled mid high phase
	idle_clks(QUART_CLKS);
	scl_m = 1'b0;
endtask

task automatic bus_start();
	sda_m = 1'b1;
	idle_clks(QUART_CLKS);
	scl_m = 1'b1;
	idle_clks(HALF_CLKS);
	sda_m = 1'b0;   // Falls while SCL is high
	idle_clks(HALF_CLKS);
	scl_m = 1'b0;
endtask

task automatic bus_stop();
	idle_clks(QUART_CLKS);
	sda_m = 1'b0;
	idle_clks(QUART_CLKS);
	scl_m = 1'b1;
	idle_clks(HALF_CLKS);
	sda_m = 1'b1;   // Rises while SCL is high
	idle_clks(HALF_CLKS);
endtask

// Eight bits MSB first, then the slave ACK bit (low means ACK)
task automatic send_byte(input byte_t data, output logic ack);
	logic level;
	for (int i = 7; i >= 0; i--)
		clock_bit(data[i], level);
	clock_bit(1'b1, ack);
endtask

// Bus released for eight bits unless force_low, then our own ACK or NACK
task automatic recv_byte(input logic nack, input logic force_low, output byte_t data);
	logic level;
	for (int i = 7; i >= 0; i--) begin
		clock_bit(!force_low, level);
		data[i] = level;
	end
	clock_bit(nack, level);
endtask

`endif

//--- verification/tb_i2c_bridge.sv
`timescale 1ns/1ns
`include "i2c_bridge_params.svh"

module tb_i2c_bridge
	import i2c_bridge_pkg::*;
;

	localparam i2c_addr_t OWN_ADDR = 7'h2A;
	localparam int NUM_TRANS = 12;   // Bus transactions in the sequence

	logic clk, rst;
	logic scl_m, sda_m, sda_bus;
	logic rx_pop_i, tx_push_i, tx_full_o, rx_empty_o;
	logic sda_pull_o, byte_valid_o;
	word_t rx_word_o, tx_word_i;
	byte_t byte_o;
	i2c_addr_t addr_o;
	stat_cnt_t wr_count_o, rd_count_o, err_count_o;

	int seed = 32'h9333;
	int checks = 0;
	int errors = 0;
	int exp_wr = 0;
	int exp_rd = 0;
	int exp_err = 0;
	int exp_valid = 0;
	int valid_seen = 0;
	byte_t exp_byte = '0;    // Byte the master is writing
	logic hold_check = 1'b0;
	word_t w;
	word_t stored [$];
	byte_t b;
	logic ack;

	assign sda_bus = sda_m & ~sda_pull_o;   // Wired-AND open drain

	i2c_bridge_top i2c_bridge_top_i (
		.clk (clk), .rst (rst), .scl_i (scl_m), .sda_i (sda_bus),
		.sda_pull_o (sda_pull_o), .own_addr_i (OWN_ADDR),
		.rx_pop_i (rx_pop_i), .rx_word_o (rx_word_o), .rx_empty_o (rx_empty_o),
		.tx_push_i (tx_push_i), .tx_word_i (tx_word_i), .tx_full_o (tx_full_o),
		.byte_o (byte_o), .byte_valid_o (byte_valid_o), .addr_o (addr_o),
		.wr_count_o (wr_count_o), .rd_count_o (rd_count_o), .err_count_o (err_count_o)
	);

	`include "i2c_master_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------
	task automatic compare(input word_t got, input word_t exp, input string what);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	a_byte_out: assert property (@(posedge clk) disable iff (rst)
		byte_valid_o |-> byte_o == exp_byte)
	else begin
		errors++;
		$display("ERR %0t: byte_o is %h, expected %h", $time, byte_o, exp_byte);
	end

	// Bus stays released through a failed read while SCL is high
	a_err_release: assert property (@(posedge clk) disable iff (rst)
		hold_check && scl_m |-> !sda_pull_o)
	else begin
		errors++;
		$display("ERR %0t: SDA pulled after read error", $time);
	end

	// Pulses of byte_valid_o so far
	always @(posedge clk) begin
		if (!rst && byte_valid_o)
			valid_seen++;
	end

	// ------------------------------------------------------------------
	// Host side and transfers
	// ------------------------------------------------------------------
	task automatic pop_and_compare(input word_t exp);
		int n;
		for (n = 0; rx_empty_o && n < 4 * HALF_CLKS; n++)
			@(negedge clk);
		if (rx_empty_o) begin
			errors++;
			$display("Receive FIFO stayed empty while a word was expected at %0t", $time);
		end
		compare(rx_word_o, exp, "rx_word_o");
		rx_pop_i = 1'b1;
		@(negedge clk);
		rx_pop_i = 1'b0;
	endtask

	task automatic push_tx_word(input word_t data);
		int n;
		for (n = 0; tx_full_o && n < 4 * HALF_CLKS; n++)
			@(negedge clk);
		tx_word_i = data;
		tx_push_i = 1'b1;
		@(negedge clk);
		tx_push_i = 1'b0;
	endtask

	task automatic write_transfer(input i2c_addr_t addr, input int nbytes,
		input word_t data, input logic acked);
		logic a;
		bus_start();
		exp_byte = {addr, 1'b0};
		send_byte({addr, 1'b0}, a);
		compare(a, !acked, "write address ACK");
		// Data follows a NACK too and the slave must ignore it
		for (int i = 0; i < nbytes; i++) begin
			exp_byte = data[31 - 8 * i -: 8];
			send_byte(exp_byte, a);
			compare(a, !acked, "data byte ACK");
			if (acked)
				exp_valid++;
		end
		if (acked)
			exp_wr++;
		bus_stop();
		compare(wr_count_o, exp_wr, "wr_count_o");
		compare(valid_seen, exp_valid, "byte_valid_o pulses");
	endtask

	task automatic read_transfer(input i2c_addr_t addr, input logic acked, input word_t exp);
		logic a;
		byte_t d;
		bus_start();
		send_byte({addr, 1'b1}, a);
		compare(a, !acked, "read address ACK");
		if (acked) begin
			for (int i = 0; i < 4; i++) begin
				recv_byte(i == 3, 1'b0, d);   // NACK on the last byte
				compare(d, exp[31 - 8 * i -: 8], "read byte");
			end
			exp_rd++;
		end
		bus_stop();
		compare(rd_count_o, exp_rd, "rd_count_o");
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin
		rst = 1'b1;
		scl_m = 1'b1;
		sda_m = 1'b1;
		rx_pop_i = 1'b0;
		tx_push_i = 1'b0;
		tx_word_i = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		idle_clks(HALF_CLKS);

		w = $random(seed);
		write_transfer(OWN_ADDR, 4, w, 1'b1);
		pop_and_compare(w);

		write_transfer(7'h15, 4, w, 1'b0);   // Nobody answers here
		compare(rx_empty_o, 1'b1, "rx_empty_o");
		write_transfer(7'h00, 0, '0, 1'b1);
		compare(addr_o, 7'h00, "addr_o");
		write_transfer(`IIC_ALIAS_ADDR0, 0, '0, 1'b1);
		compare(addr_o, `IIC_ALIAS_ADDR0, "addr_o");

		w = $random(seed);
		push_tx_word(w);
		read_transfer(OWN_ADDR, 1'b1, w);
		compare(tx_full_o, 1'b0, "tx_full_o");

		// Back-pressure in both directions
		read_transfer(OWN_ADDR, 1'b0, '0);
		for (int n = 0; n < `BRIDGE_FIFO_DEPTH; n++) begin
			w = $random(seed);
			stored.push_back(w);
			write_transfer(OWN_ADDR, 4, w, 1'b1);
		end
		write_transfer(OWN_ADDR, 4, '0, 1'b0);
		while (stored.size() > 0)
			pop_and_compare(stored.pop_front());
		compare(rx_empty_o, 1'b1, "rx_empty_o");

		// Master holds SDA low against a 1 from the slave
		w = $random(seed) | 32'h8000_0000;
		push_tx_word(w);
		bus_start();
		send_byte({OWN_ADDR, 1'b1}, ack);
		compare(ack, 1'b0, "read address ACK");
		hold_check = 1'b1;
		recv_byte(1'b1, 1'b1, b);
		bus_stop();
		hold_check = 1'b0;
		exp_err++;
		compare(err_count_o, exp_err, "err_count_o");
		compare(rd_count_o, exp_rd, "rd_count_o");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		repeat (NUM_TRANS * 5 * 9 * 64 + 2000) @(posedge clk);
		$display("Timeout: the test sequence did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verilog
+incdir+verification
verilog/i2c_bridge_pkg.sv
verilog/i2c_line_if.sv
verilog/i2c_line_filter.sv
verilog/i2c_slave_phy.sv
verilog/word_fifo.sv
verilog/i2c_bridge_status.sv
verilog/i2c_bridge_top.sv
verification/tb_i2c_bridge.sv
